// ==== logic/muscle_pkg.sv ====
package muscle_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // number format
    ////////////////////////////////////////////////////////////////////////////

    // signed q16.16, one lsb is 2^-16
    typedef logic signed [31:0] fix_t;

    localparam int FRAC_BITS = 16;

    // spike count lands at 2^(SPIKE_SHIFT - FRAC_BITS) per spike
    localparam int SPIKE_SHIFT = 10;

    // euler step of 2^-10 per clock
    localparam int DT_SHIFT = 10;

    // four contraction times selectable at run time
    localparam int TAU_SEL_W = 2;
    localparam int N_TAU = 2 ** TAU_SEL_W;

    ////////////////////////////////////////////////////////////////////////////
    // length-weight curve
    ////////////////////////////////////////////////////////////////////////////

    // region breakpoints 0.5, 1.0, 2.0
    localparam fix_t W_LO = 32'sh0000_8000;
    localparam fix_t W_MID = 32'sh0001_0000;
    localparam fix_t W_HI = 32'sh0002_0000;

    // middle region -4x^2 + 8x - 3
    localparam fix_t WM_C2 = -32'sd262144;
    localparam fix_t WM_C1 = 32'sd524288;
    localparam fix_t WM_C0 = -32'sd196608;

    // upper region -x^2 + 2x
    localparam fix_t WH_C2 = -32'sd65536;
    localparam fix_t WH_C1 = 32'sd131072;

    ////////////////////////////////////////////////////////////////////////////
    // twitch coefficients, index 0..3 is tau of 10, 20, 40, 80 ms
    ////////////////////////////////////////////////////////////////////////////

    // b1 = e * T * a / tau with a = exp(-T / tau), T = 1 ms
    localparam fix_t TW_B1 [0:N_TAU-1] = '{32'sd16119, 32'sd8473, 32'sd4344, 32'sd2199};
    // a1 = -2a
    localparam fix_t TW_A1 [0:N_TAU-1] = '{-32'sd118599, -32'sd124680,
                                            -32'sd127836, -32'sd129444};
    // a2 = a^2
    localparam fix_t TW_A2 [0:N_TAU-1] = '{32'sd53656, 32'sd59299, 32'sd62340, 32'sd63918};

    ////////////////////////////////////////////////////////////////////////////
    // force equation
    ////////////////////////////////////////////////////////////////////////////

    // passive spring 204.0 above rest length
    localparam fix_t K_LEN = 32'sd13369344;
    // damping 136.0
    localparam fix_t K_VEL = 32'sd8912896;
    // force decay 4.22
    localparam fix_t K_T = 32'sd276562;
    // active drive 2.72
    localparam fix_t K_ACT = 32'sd178258;
    // rest length 1.0
    localparam fix_t REST_LEN = 32'sd65536;

    // full 64-bit product, floor shift back to q16.16
    function automatic fix_t fx_mul(input fix_t a, input fix_t b);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        prod = prod >>> FRAC_BITS;
        return prod[31:0];
    endfunction

endpackage

// ==== logic/stage_if.sv ====
`timescale 1ns/1ps

interface stage_if;
    import muscle_pkg::*;

    // spike count as fixed point
    fix_t spike_fx;
    // length weight of the same sample
    fix_t weight;
    // length and lengthening velocity, held for the force stage
    fix_t pos;
    fix_t vel;

    // input stage drives, twitch filter reads
    modport src (output spike_fx, weight, pos, vel);
    modport dst (input spike_fx, weight, pos, vel);

endinterface

// ==== logic/muscle_input_stage.sv ====
`timescale 1ns/1ps

module muscle_input_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic [15:0]      spike_cnt_i,
    input  muscle_pkg::fix_t pos_i,
    input  muscle_pkg::fix_t vel_i,
    stage_if.src             stg_o
);
    import muscle_pkg::*;

    // spike count widened and scaled
    fix_t spike_fx;
    // x^2 shared by both quadratics
    fix_t pos_sq;
    // candidate weights per region
    fix_t w_mid;
    fix_t w_hi;
    // selected weight
    fix_t weight;

    ////////////////////////////////////////////////////////////////////////////
    // spike conversion
    ////////////////////////////////////////////////////////////////////////////

    // zero-extend to 32 bits then place the count above the gain shift
    // 16-bit count << 10 stays inside 26 bits, so the sign bit never sets
    assign spike_fx = fix_t'({16'd0, spike_cnt_i}) <<< SPIKE_SHIFT;

    ////////////////////////////////////////////////////////////////////////////
    // length-weight curve
    ////////////////////////////////////////////////////////////////////////////

    assign pos_sq = fx_mul(pos_i, pos_i);

    // rising part, 0 at 0.5 and 1 at 1.0
    assign w_mid = fx_mul(WM_C2, pos_sq) + fx_mul(WM_C1, pos_i) + WM_C0;

    // falling part, 1 at 1.0 and 0 at 2.0
    assign w_hi = fx_mul(WH_C2, pos_sq) + fx_mul(WH_C1, pos_i);

    // region select, signed compare so negative lengths fall into zero
    always_comb begin
        if (pos_i <= W_LO) begin
            weight = '0;
        end else if (pos_i <= W_MID) begin
            weight = w_mid;
        end else if (pos_i <= W_HI) begin
            weight = w_hi;
        end else begin
            // overstretched, no active force
            weight = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sample register
    ////////////////////////////////////////////////////////////////////////////

    // all four values of one sample move together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stg_o.spike_fx <= '0;
            stg_o.weight <= '0;
            stg_o.pos <= '0;
            stg_o.vel <= '0;
        end else begin
            stg_o.spike_fx <= spike_fx;
            stg_o.weight <= weight;
            stg_o.pos <= pos_i;
            stg_o.vel <= vel_i;
        end
    end

endmodule

// ==== logic/twitch_filter.sv ====
`timescale 1ns/1ps

module twitch_filter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [muscle_pkg::TAU_SEL_W-1:0] tau_sel_i,
    stage_if.dst                             stg_i,
    output muscle_pkg::fix_t                 h_o,
    output muscle_pkg::fix_t                 active_force_o
);
    import muscle_pkg::*;

    // coefficient set for the selected contraction time
    fix_t b1;
    fix_t a1;
    fix_t a2;

    // twitch history, h1 is the last value and h2 the one before
    fix_t h1;
    fix_t h2;

    // recurrence terms
    fix_t term_x;
    fix_t term_h1;
    fix_t term_h2;
    fix_t h_new;

    // registered weighted twitch
    fix_t active_q;

    ////////////////////////////////////////////////////////////////////////////
    // coefficient lookup
    ////////////////////////////////////////////////////////////////////////////

    // tau select may change mid-run, history carries over unchanged
    assign b1 = TW_B1[tau_sel_i];
    assign a1 = TW_A1[tau_sel_i];
    assign a2 = TW_A2[tau_sel_i];

    ////////////////////////////////////////////////////////////////////////////
    // second-order recurrence
    ////////////////////////////////////////////////////////////////////////////

    // stage register already holds the previous spike sample
    assign term_x = fx_mul(b1, stg_i.spike_fx);

    // a1 is negative, so subtracting it adds 2a * h1
    assign term_h1 = fx_mul(a1, h1);
    assign term_h2 = fx_mul(a2, h2);

    // the b2 term of the twitch model is zero and is left out
    assign h_new = term_x - term_h1 - term_h2;

    // history shift and weighted output in the same edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h1 <= '0;
            h2 <= '0;
            active_q <= '0;
        end else begin
            h1 <= h_new;
            h2 <= h1;
            // weight is from the same stage sample as the spike
            active_q <= fx_mul(stg_i.weight, h_new);
        end
    end

    assign h_o = h1;
    assign active_force_o = active_q;

endmodule

// ==== logic/force_integrator.sv ====
`timescale 1ns/1ps

module force_integrator (
    input  logic             clk,
    input  logic             reset,
    input  muscle_pkg::fix_t active_force_i,
    input  muscle_pkg::fix_t pos_i,
    input  muscle_pkg::fix_t vel_i,
    output muscle_pkg::fix_t total_force_o,
    output muscle_pkg::fix_t d_force_o
);
    import muscle_pkg::*;

    // length above rest, may be negative
    fix_t stretch;

    // force-rate terms
    fix_t passive;
    fix_t damping;
    fix_t decay;
    fix_t drive;
    fix_t rate;

    // integrator state
    fix_t d_force_q;
    fix_t total_q;

    ////////////////////////////////////////////////////////////////////////////
    // force rate
    ////////////////////////////////////////////////////////////////////////////

    assign stretch = pos_i - REST_LEN;

    // slack muscle gives no spring force
    assign passive = stretch[31] ? '0 : fx_mul(K_LEN, stretch);

    // velocity damping, either sign
    assign damping = fx_mul(K_VEL, vel_i);

    // self decay on the current total force
    assign decay = fx_mul(K_T, total_q);

    // contribution of the weighted twitch
    assign drive = fx_mul(K_ACT, active_force_i);

    // plain wrapping sums
    assign rate = passive + damping - decay + drive;

    ////////////////////////////////////////////////////////////////////////////
    // euler step
    ////////////////////////////////////////////////////////////////////////////

    // total uses the rate registered one edge earlier
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            d_force_q <= '0;
            total_q <= '0;
        end else begin
            d_force_q <= rate;
            // arithmetic shift keeps negative rates negative
            total_q <= total_q + (d_force_q >>> DT_SHIFT);
        end
    end

    assign d_force_o = d_force_q;
    assign total_force_o = total_q;

endmodule

// ==== logic/muscle_top.sv ====
`timescale 1ns/1ps

module muscle_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [15:0]                      spike_cnt_i,
    input  muscle_pkg::fix_t                 pos_i,
    input  muscle_pkg::fix_t                 vel_i,
    input  logic [muscle_pkg::TAU_SEL_W-1:0] tau_sel_i,
    output muscle_pkg::fix_t                 active_force_o,
    output muscle_pkg::fix_t                 total_force_o,
    output muscle_pkg::fix_t                 d_force_o
);

    ////////////////////////////////////////////////////////////////////////////
    // pipeline
    ////////////////////////////////////////////////////////////////////////////

    // registered sample between input stage and twitch filter
    stage_if stg ();

    // edge n, convert spikes and weigh the length
    muscle_input_stage u_input (
        .clk         (clk),
        .reset       (reset),
        .spike_cnt_i (spike_cnt_i),
        .pos_i       (pos_i),
        .vel_i       (vel_i),
        .stg_o       (stg)
    );

    // edge n+1, twitch value and weighted activation
    // raw twitch is reachable hierarchically for debug
    twitch_filter u_twitch (
        .clk            (clk),
        .reset          (reset),
        .tau_sel_i      (tau_sel_i),
        .stg_i          (stg),
        .h_o            (),
        .active_force_o (active_force_o)
    );

    // edge n+2, force rate and total force
    // length and velocity come from the stage register
    force_integrator u_force (
        .clk            (clk),
        .reset          (reset),
        .active_force_i (active_force_o),
        .pos_i          (stg.pos),
        .vel_i          (stg.vel),
        .total_force_o  (total_force_o),
        .d_force_o      (d_force_o)
    );

endmodule

// ==== tb/muscle_chk.sv ====
`timescale 1ns/1ps

module muscle_chk (
    input logic             clk,
    input logic             reset,
    input muscle_pkg::fix_t pos_i,
    input muscle_pkg::fix_t active_force_i,
    input muscle_pkg::fix_t total_force_i,
    input muscle_pkg::fix_t d_force_i
);
    import muscle_pkg::*;

    // all outputs held at zero in reset
    assert property (@(posedge clk)
        reset |-> (active_force_i == 0 && total_force_i == 0 && d_force_i == 0))
        else $error("outputs not zero while reset is high");

    // total moves only by the rate seen one edge before
    assert property (@(posedge clk) disable iff (reset)
        total_force_i == $past(total_force_i) + ($signed($past(d_force_i)) >>> DT_SHIFT))
        else $error("total force changed by something other than the shifted rate");

    // registered length outside the weight curve gives no activation one edge later
    assert property (@(posedge clk) disable iff (reset)
        ($past(pos_i) <= W_LO || $past(pos_i) > W_HI) |-> (active_force_i == 0))
        else $error("active force nonzero for a length outside the weight curve");

endmodule

bind muscle_top muscle_chk chk0 (
    .clk            (clk),
    .reset          (reset),
    .pos_i          (stg.pos),
    .active_force_i (active_force_o),
    .total_force_i  (total_force_o),
    .d_force_i      (d_force_o)
);

// ==== tb/muscle_model.svh ====
`ifndef MUSCLE_MODEL_SVH
`define MUSCLE_MODEL_SVH

// one in q16.16
localparam fix_t ONE = 32'sd65536;

// mirror of every pipeline register in the DUT
fix_t m_spike;
fix_t m_weight;
fix_t m_pos;
fix_t m_vel;
fix_t m_h1;
fix_t m_h2;
fix_t m_act;
fix_t m_dforce;
fix_t m_total;

// q16.16 product, floor of the full product
function automatic fix_t q_mul(input fix_t a, input fix_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return fix_t'(p >>> 16);
endfunction

// piecewise length weight, zero outside 0.5 .. 2.0
function automatic fix_t len_weight(input fix_t x);
    fix_t x2;
    x2 = q_mul(x, x);
    if (x <= ONE / 2) begin
        return '0;
    end else if (x <= ONE) begin
        return q_mul(-4 * ONE, x2) + q_mul(8 * ONE, x) - 3 * ONE;
    end else if (x <= 2 * ONE) begin
        return q_mul(-1 * ONE, x2) + q_mul(2 * ONE, x);
    end
    return '0;
endfunction

function automatic void model_reset();
    m_spike = '0;
    m_weight = '0;
    m_pos = '0;
    m_vel = '0;
    m_h1 = '0;
    m_h2 = '0;
    m_act = '0;
    m_dforce = '0;
    m_total = '0;
endfunction

// one clock edge, all right-hand sides are the values before the edge
function automatic void model_step(input logic [15:0] spk, input fix_t p, input fix_t v,
                                   input logic [1:0] ts);
    fix_t h_new;
    fix_t rate;
    h_new = q_mul(TW_B1[ts], m_spike) - q_mul(TW_A1[ts], m_h1) - q_mul(TW_A2[ts], m_h2);
    rate = q_mul(K_VEL, m_vel) - q_mul(K_T, m_total) + q_mul(K_ACT, m_act);
    // spring only pulls when stretched past rest
    if (m_pos > REST_LEN) begin
        rate = rate + q_mul(K_LEN, m_pos - REST_LEN);
    end
    m_total = m_total + (m_dforce >>> DT_SHIFT);
    m_dforce = rate;
    m_act = q_mul(m_weight, h_new);
    m_h2 = m_h1;
    m_h1 = h_new;
    m_spike = int'(spk) * (2 ** SPIKE_SHIFT);
    m_weight = len_weight(p);
    m_pos = p;
    m_vel = v;
endfunction

`endif

// ==== tb/muscle_tb.sv ====
`timescale 1ns/1ps

module muscle_tb;
    import muscle_pkg::*;

    // test lengths in clocks
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_LEN = 20;
    localparam int IMPULSE_LEN = 140;
    localparam int REGION_LEN = 50;
    localparam int PASSIVE_LEN = 100;
    localparam int SLACK_LEN = 40;
    localparam int VEL_LEN = 40;
    localparam int RANDOM_LEN = 200;
    // seven resets for the start, each tau and the two passive runs
    localparam int TIMEOUT_CYCLES = 7 * RESET_CYCLES + IDLE_LEN + 4 * IMPULSE_LEN
        + 4 * REGION_LEN + PASSIVE_LEN + SLACK_LEN + VEL_LEN + RANDOM_LEN + 50;

    logic        clk;
    logic        reset;
    logic [15:0] spike_cnt;
    fix_t        pos;
    fix_t        vel;
    logic [1:0]  tau_sel;
    fix_t        active_force;
    fix_t        total_force;
    fix_t        d_force;

    int err_cnt = 0;
    int check_cnt = 0;
    int cycle_cnt = 0;

    `include "muscle_model.svh"

    muscle_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .spike_cnt_i    (spike_cnt),
        .pos_i          (pos),
        .vel_i          (vel),
        .tau_sel_i      (tau_sel),
        .active_force_o (active_force),
        .total_force_o  (total_force),
        .d_force_o      (d_force)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare(input string name, input fix_t got, input fix_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // drives one sample and checks the outputs 5 ns after the edge
    task automatic run_cycle(input logic [15:0] spk, input fix_t p, input fix_t v,
                             input logic [1:0] ts);
        spike_cnt = spk;
        pos = p;
        vel = v;
        tau_sel = ts;
        @(posedge clk);
        model_step(spk, p, v, ts);
        #5;
        compare("active_force_o", active_force, m_act);
        compare("total_force_o", total_force, m_total);
        compare("d_force_o", d_force, m_dforce);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        spike_cnt = '0;
        pos = '0;
        vel = '0;
        tau_sel = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        for (int k = 0; k < IDLE_LEN; k++) begin
            run_cycle('0, '0, '0, 2'd0);
        end
    endtask

    // the twitch peak of a single spike at rest length moves out with tau
    task automatic twitch_impulse();
        int peak_at [4];
        fix_t peak_val;
        logic [15:0] cnt;
        for (int t = 0; t < 4; t++) begin
            apply_reset();
            cnt = 16'($urandom_range(200, 1));
            peak_val = '0;
            peak_at[t] = 0;
            for (int k = 0; k < IMPULSE_LEN; k++) begin
                run_cycle((k == 0) ? cnt : 16'd0, REST_LEN, '0, 2'(t));
                if (active_force > peak_val) begin
                    peak_val = active_force;
                    peak_at[t] = k;
                end
            end
            if (peak_val <= 0) begin
                err_cnt++;
                $display("no twitch response for tau select %0d", t);
            end
            if (t > 0 && peak_at[t] <= peak_at[t-1]) begin
                err_cnt++;
                $display("twitch peak for tau select %0d at cycle %0d is not later than %0d",
                         t, peak_at[t], peak_at[t-1]);
            end
        end
    endtask

    // lengths 0.4, 0.8, 1.5 and 2.5 under a steady spike train
    task automatic weight_regions();
        fix_t lens [4];
        lens = '{32'sd26214, 32'sd52429, 32'sd98304, 32'sd163840};
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < REGION_LEN; k++) begin
                run_cycle(16'd8, lens[r], '0, 2'd0);
                // outside the curve the weight is zero
                if ((r == 0 || r == 3) && k >= 3) begin
                    compare("active_force_o", active_force, '0);
                end
            end
        end
    endtask

    task automatic passive_and_velocity();
        apply_reset();
        for (int k = 0; k < PASSIVE_LEN; k++) begin
            run_cycle('0, 32'sd98304, '0, 2'd0);
        end
        if (total_force <= 0) begin
            err_cnt++;
            $display("total force did not rise with the muscle stretched");
        end
        apply_reset();
        // slack muscle at rest gives no force at all
        for (int k = 0; k < SLACK_LEN; k++) begin
            run_cycle('0, 32'sd52429, '0, 2'd0);
            compare("total_force_o", total_force, '0);
            compare("d_force_o", d_force, '0);
        end
        // with 0.25 velocity the first rate after the stage edge is 136 * 0.25
        for (int k = 0; k < VEL_LEN; k++) begin
            run_cycle('0, 32'sd52429, 32'sd16384, 2'd0);
            if (k == 1) begin
                compare("d_force_o", d_force, 32'sd136 * 32'sd16384);
            end
        end
    endtask

    // random samples with the tau select switched halfway
    task automatic random_sequence();
        for (int k = 0; k < RANDOM_LEN; k++) begin
            run_cycle(16'($urandom_range(63, 0)), fix_t'($urandom_range(170394, 19661)),
                      fix_t'($urandom_range(65536, 0)) - 32'sd32768,
                      (k < RANDOM_LEN / 2) ? 2'd1 : 2'd3);
        end
    endtask

    initial begin
        void'($urandom(32'h7ee7));
        apply_reset();
        idle_after_reset();
        twitch_impulse();
        weight_regions();
        passive_and_velocity();
        random_sequence();
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+tb
logic/muscle_pkg.sv
logic/stage_if.sv
logic/muscle_input_stage.sv
logic/twitch_filter.sv
logic/force_integrator.sv
logic/muscle_top.sv
tb/muscle_chk.sv
tb/muscle_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the muscle model testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -Wno-fatal \
    --top-module muscle_tb \
    -f compile.f \
    -o muscle_sim

# the log decides the result, not the exit status of the simulation
./obj_dir/muscle_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation ok, see sim.log"
else
    echo "simulation reported errors, see sim.log"
    exit 1
fi
